// ==== hw/mem_merge_pkg.sv ====
package mem_merge_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int NumSrc     = 3;  // dcache, bypass, icache
    localparam int WFifoDepth = 4;  // outstanding writes awaiting W data

    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  len_t;   // beats minus one
    typedef logic [63:0] data_t;
    typedef logic [1:0]  src_idx_t;

    // write-order FIFO pointers and fill level
    typedef logic [$clog2(WFifoDepth)-1:0]   wptr_t;
    typedef logic [$clog2(WFifoDepth+1)-1:0] wcnt_t;

    // --------------------
    // requester indices
    // --------------------
    localparam src_idx_t SrcDcache = 2'd0;
    localparam src_idx_t SrcBypass = 2'd1;
    localparam src_idx_t SrcIcache = 2'd2;

    // maps a transaction ID back to the requester that issued it
    function automatic src_idx_t src_of_id(input axi_id_t id);
        case (id) inside
            4'b1100: return SrcDcache;
            4'b10??: return SrcBypass;  // 1000 to 1011
            default: return SrcIcache;  // 0000 and anything unlisted
        endcase
    endfunction

endpackage

// ==== hw/addr_chan_if.sv ====
interface addr_chan_if;
    import mem_merge_pkg::*;

    logic    valid;
    logic    ready;
    axi_id_t id;
    addr_t   addr;
    len_t    len;  // burst length minus one

    modport mgr (
        output valid, id, addr, len,
        input  ready
    );

    modport sub (
        input  valid, id, addr, len,
        output ready
    );

    // passive observer, e.g. for tracing
    modport mon (
        input valid, ready, id, addr, len
    );

endinterface

// ==== hw/addr_arbiter.sv ====
module addr_arbiter (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic              [mem_merge_pkg::NumSrc-1:0] src_valid_i,
    output logic              [mem_merge_pkg::NumSrc-1:0] src_ready_o,
    input  mem_merge_pkg::axi_id_t [mem_merge_pkg::NumSrc-1:0] src_id_i,
    input  mem_merge_pkg::addr_t   [mem_merge_pkg::NumSrc-1:0] src_addr_i,
    input  mem_merge_pkg::len_t    [mem_merge_pkg::NumSrc-1:0] src_len_i,
    addr_chan_if.mgr                                      out_o
);
    import mem_merge_pkg::*;

    src_idx_t ptr_q;       // highest priority source this round
    logic     lock_q;      // output stalled, keep the grant
    src_idx_t lock_src_q;
    src_idx_t grant;
    src_idx_t cand;
    src_idx_t next_ptr;
    logic     found;

    // --------------------
    // grant selection
    // --------------------
    always_comb begin
        grant = ptr_q;
        found = 1'b0;
        cand  = ptr_q;
        for (int i = 0; i < NumSrc; i++) begin
            cand = src_idx_t'((int'(ptr_q) + i) % NumSrc);
            if (!found && src_valid_i[cand]) begin
                grant = cand;
                found = 1'b1;
            end
        end
        if (lock_q) begin
            grant = lock_src_q;  // back-pressure, hold the winner
        end
    end

    assign next_ptr = src_idx_t'((int'(grant) + 1) % NumSrc);

    // --------------------
    // output channel
    // --------------------
    assign out_o.valid = |src_valid_i;
    assign out_o.id    = src_id_i[grant];
    assign out_o.addr  = src_addr_i[grant];
    assign out_o.len   = src_len_i[grant];

    always_comb begin
        src_ready_o        = '0;
        src_ready_o[grant] = out_o.ready & src_valid_i[grant];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q      <= SrcDcache;
            lock_q     <= 1'b0;
            lock_src_q <= SrcDcache;
        end else if (out_o.valid && out_o.ready) begin
            ptr_q  <= next_ptr;  // winner goes to the back
            lock_q <= 1'b0;
        end else if (out_o.valid) begin
            lock_q     <= 1'b1;
            lock_src_q <= grant;
        end
    end

endmodule

// ==== hw/wdata_router.sv ====
module wdata_router (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    addr_chan_if.sub                                    aw_i,
    addr_chan_if.mgr                                    aw_o,
    input  logic            [mem_merge_pkg::NumSrc-1:0] src_w_valid_i,
    output logic            [mem_merge_pkg::NumSrc-1:0] src_w_ready_o,
    input  mem_merge_pkg::data_t [mem_merge_pkg::NumSrc-1:0] src_w_data_i,
    input  logic            [mem_merge_pkg::NumSrc-1:0] src_w_last_i,
    output logic                                        mem_w_valid_o,
    input  logic                                        mem_w_ready_i,
    output mem_merge_pkg::data_t                        mem_w_data_o,
    output logic                                        mem_w_last_o
);
    import mem_merge_pkg::*;

    // owner of each accepted write, in AW order
    src_idx_t fifo_q [WFifoDepth];
    wptr_t    rd_ptr_q;
    wptr_t    wr_ptr_q;
    wcnt_t    count_q;

    logic     full;
    logic     empty;
    logic     push;
    logic     pop;
    src_idx_t head;

    assign full  = (count_q == wcnt_t'(WFifoDepth));
    assign empty = (count_q == '0);
    assign head  = fifo_q[rd_ptr_q];

    // --------------------
    // AW pass-through
    // --------------------
    assign aw_o.valid = aw_i.valid & ~full;  // no slot, no new write
    assign aw_o.id    = aw_i.id;
    assign aw_o.addr  = aw_i.addr;
    assign aw_o.len   = aw_i.len;
    assign aw_i.ready = aw_o.ready & ~full;

    assign push = aw_o.valid & aw_o.ready;
    assign pop  = mem_w_valid_o & mem_w_ready_i & mem_w_last_o;  // burst done

    // --------------------
    // W mux
    // --------------------
    assign mem_w_valid_o = ~empty & src_w_valid_i[head];
    assign mem_w_data_o  = src_w_data_i[head];
    assign mem_w_last_o  = src_w_last_i[head];

    always_comb begin
        src_w_ready_o = '0;
        if (!empty) begin
            src_w_ready_o[head] = mem_w_ready_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= src_of_id(aw_o.id);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == wptr_t'(WFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == wptr_t'(WFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== hw/resp_router.sv ====
module resp_router (
    // read response
    input  logic                                   mem_r_valid_i,
    output logic                                   mem_r_ready_o,
    input  mem_merge_pkg::axi_id_t                 mem_r_id_i,
    output logic       [mem_merge_pkg::NumSrc-1:0] src_r_valid_o,
    input  logic       [mem_merge_pkg::NumSrc-1:0] src_r_ready_i,
    // write response
    input  logic                                   mem_b_valid_i,
    output logic                                   mem_b_ready_o,
    input  mem_merge_pkg::axi_id_t                 mem_b_id_i,
    output logic       [mem_merge_pkg::NumSrc-1:0] src_b_valid_o,
    input  logic       [mem_merge_pkg::NumSrc-1:0] src_b_ready_i
);
    import mem_merge_pkg::*;

    src_idx_t r_sel;
    src_idx_t b_sel;

    // dcache 1100, bypass 10xx, everything else to the icache
    assign r_sel = src_of_id(mem_r_id_i);
    assign b_sel = src_of_id(mem_b_id_i);

    // --------------------
    // R demux
    // --------------------
    always_comb begin
        src_r_valid_o        = '0;
        src_r_valid_o[r_sel] = mem_r_valid_i;
    end

    assign mem_r_ready_o = src_r_ready_i[r_sel];

    // --------------------
    // B demux
    // --------------------
    always_comb begin
        src_b_valid_o        = '0;
        src_b_valid_o[b_sel] = mem_b_valid_i;
    end

    assign mem_b_ready_o = src_b_ready_i[b_sel];  // only the owner can stall memory

endmodule

// ==== hw/mem_port_merge.sv ====
module mem_port_merge (
    input  logic                                               clk_i,
    input  logic                                               rst_i,
    // AR from the requesters
    input  logic                   [mem_merge_pkg::NumSrc-1:0] src_ar_valid_i,
    output logic                   [mem_merge_pkg::NumSrc-1:0] src_ar_ready_o,
    input  mem_merge_pkg::axi_id_t [mem_merge_pkg::NumSrc-1:0] src_ar_id_i,
    input  mem_merge_pkg::addr_t   [mem_merge_pkg::NumSrc-1:0] src_ar_addr_i,
    input  mem_merge_pkg::len_t    [mem_merge_pkg::NumSrc-1:0] src_ar_len_i,
    // AW from the requesters
    input  logic                   [mem_merge_pkg::NumSrc-1:0] src_aw_valid_i,
    output logic                   [mem_merge_pkg::NumSrc-1:0] src_aw_ready_o,
    input  mem_merge_pkg::axi_id_t [mem_merge_pkg::NumSrc-1:0] src_aw_id_i,
    input  mem_merge_pkg::addr_t   [mem_merge_pkg::NumSrc-1:0] src_aw_addr_i,
    input  mem_merge_pkg::len_t    [mem_merge_pkg::NumSrc-1:0] src_aw_len_i,
    // W from the requesters
    input  logic                   [mem_merge_pkg::NumSrc-1:0] src_w_valid_i,
    output logic                   [mem_merge_pkg::NumSrc-1:0] src_w_ready_o,
    input  mem_merge_pkg::data_t   [mem_merge_pkg::NumSrc-1:0] src_w_data_i,
    input  logic                   [mem_merge_pkg::NumSrc-1:0] src_w_last_i,
    // R and B handshakes per requester
    output logic                   [mem_merge_pkg::NumSrc-1:0] src_r_valid_o,
    input  logic                   [mem_merge_pkg::NumSrc-1:0] src_r_ready_i,
    output logic                   [mem_merge_pkg::NumSrc-1:0] src_b_valid_o,
    input  logic                   [mem_merge_pkg::NumSrc-1:0] src_b_ready_i,
    // response payload, same for every requester
    output mem_merge_pkg::axi_id_t                             src_r_id_o,
    output mem_merge_pkg::data_t                               src_r_data_o,
    output logic                                               src_r_last_o,
    output mem_merge_pkg::axi_id_t                             src_b_id_o,
    // memory AR
    output logic                                               mem_ar_valid_o,
    input  logic                                               mem_ar_ready_i,
    output mem_merge_pkg::axi_id_t                             mem_ar_id_o,
    output mem_merge_pkg::addr_t                               mem_ar_addr_o,
    output mem_merge_pkg::len_t                                mem_ar_len_o,
    // memory AW
    output logic                                               mem_aw_valid_o,
    input  logic                                               mem_aw_ready_i,
    output mem_merge_pkg::axi_id_t                             mem_aw_id_o,
    output mem_merge_pkg::addr_t                               mem_aw_addr_o,
    output mem_merge_pkg::len_t                                mem_aw_len_o,
    // memory W
    output logic                                               mem_w_valid_o,
    input  logic                                               mem_w_ready_i,
    output mem_merge_pkg::data_t                               mem_w_data_o,
    output logic                                               mem_w_last_o,
    // memory R
    input  logic                                               mem_r_valid_i,
    output logic                                               mem_r_ready_o,
    input  mem_merge_pkg::axi_id_t                             mem_r_id_i,
    input  mem_merge_pkg::data_t                               mem_r_data_i,
    input  logic                                               mem_r_last_i,
    // memory B
    input  logic                                               mem_b_valid_i,
    output logic                                               mem_b_ready_o,
    input  mem_merge_pkg::axi_id_t                             mem_b_id_i
);

    addr_chan_if ar_out ();
    addr_chan_if aw_arb ();  // arbiter to write router
    addr_chan_if aw_ex ();   // write router to memory

    // --------------------
    // read address
    // --------------------
    addr_arbiter ar_arb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .src_valid_i (src_ar_valid_i),
        .src_ready_o (src_ar_ready_o),
        .src_id_i    (src_ar_id_i),
        .src_addr_i  (src_ar_addr_i),
        .src_len_i   (src_ar_len_i),
        .out_o       (ar_out)
    );

    assign mem_ar_valid_o = ar_out.valid;
    assign mem_ar_id_o    = ar_out.id;
    assign mem_ar_addr_o  = ar_out.addr;
    assign mem_ar_len_o   = ar_out.len;
    assign ar_out.ready   = mem_ar_ready_i;

    // --------------------
    // write address and data
    // --------------------
    addr_arbiter aw_arb_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .src_valid_i (src_aw_valid_i),
        .src_ready_o (src_aw_ready_o),
        .src_id_i    (src_aw_id_i),
        .src_addr_i  (src_aw_addr_i),
        .src_len_i   (src_aw_len_i),
        .out_o       (aw_arb)
    );

    wdata_router wdata_router_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .aw_i          (aw_arb),
        .aw_o          (aw_ex),
        .src_w_valid_i (src_w_valid_i),
        .src_w_ready_o (src_w_ready_o),
        .src_w_data_i  (src_w_data_i),
        .src_w_last_i  (src_w_last_i),
        .mem_w_valid_o (mem_w_valid_o),
        .mem_w_ready_i (mem_w_ready_i),
        .mem_w_data_o  (mem_w_data_o),
        .mem_w_last_o  (mem_w_last_o)
    );

    assign mem_aw_valid_o = aw_ex.valid;
    assign mem_aw_id_o    = aw_ex.id;
    assign mem_aw_addr_o  = aw_ex.addr;
    assign mem_aw_len_o   = aw_ex.len;
    assign aw_ex.ready    = mem_aw_ready_i;

    // --------------------
    // responses
    // --------------------
    resp_router resp_router_i (
        .mem_r_valid_i (mem_r_valid_i),
        .mem_r_ready_o (mem_r_ready_o),
        .mem_r_id_i    (mem_r_id_i),
        .src_r_valid_o (src_r_valid_o),
        .src_r_ready_i (src_r_ready_i),
        .mem_b_valid_i (mem_b_valid_i),
        .mem_b_ready_o (mem_b_ready_o),
        .mem_b_id_i    (mem_b_id_i),
        .src_b_valid_o (src_b_valid_o),
        .src_b_ready_i (src_b_ready_i)
    );

    assign src_r_id_o   = mem_r_id_i;  // requesters filter on their own valid
    assign src_r_data_o = mem_r_data_i;
    assign src_r_last_o = mem_r_last_i;
    assign src_b_id_o   = mem_b_id_i;

endmodule

// ==== sim/tb_mem_port_merge.sv ====
module tb_mem_port_merge;
    import mem_merge_pkg::*;

    typedef logic [NumSrc-1:0] src_vec_t;

    // one cycle of stimulus plus what the outputs must show in that cycle
    typedef struct {
        int                   test;
        src_vec_t             ar_v, aw_v, w_v, w_last, r_rdy, b_rdy;
        axi_id_t [NumSrc-1:0] ar_id, aw_id;
        addr_t   [NumSrc-1:0] ar_addr, aw_addr;
        len_t    [NumSrc-1:0] ar_len, aw_len;
        data_t   [NumSrc-1:0] w_data;
        logic                 mem_ar_rdy, mem_aw_rdy, mem_w_rdy, mem_r_v, mem_b_v;
        axi_id_t              mem_r_id, mem_b_id;
        data_t                mem_r_data;
        logic                 mem_r_last;
        axi_id_t              e_ar_id, e_aw_id;
        addr_t                e_ar_addr, e_aw_addr;
        len_t                 e_ar_len, e_aw_len;
        data_t                e_w_data;
        logic                 e_w_last;
        src_vec_t             e_mem_vld;  // {w, aw, ar}
        src_vec_t             e_mem_rdy;  // {0, b, r}
        src_vec_t             e_ar_rdy, e_aw_rdy, e_w_rdy, e_r_v, e_b_v;
    } row_t;

    logic                 clk_i, rst_i;
    src_vec_t             src_ar_valid_i, src_ar_ready_o, src_aw_valid_i, src_aw_ready_o;
    src_vec_t             src_w_valid_i, src_w_ready_o, src_w_last_i;
    src_vec_t             src_r_valid_o, src_r_ready_i, src_b_valid_o, src_b_ready_i;
    axi_id_t [NumSrc-1:0] src_ar_id_i, src_aw_id_i;
    addr_t   [NumSrc-1:0] src_ar_addr_i, src_aw_addr_i;
    len_t    [NumSrc-1:0] src_ar_len_i, src_aw_len_i;
    data_t   [NumSrc-1:0] src_w_data_i;
    axi_id_t              src_r_id_o, src_b_id_o, mem_ar_id_o, mem_aw_id_o;
    axi_id_t              mem_r_id_i, mem_b_id_i;
    data_t                src_r_data_o, mem_w_data_o, mem_r_data_i;
    addr_t                mem_ar_addr_o, mem_aw_addr_o;
    len_t                 mem_ar_len_o, mem_aw_len_o;
    logic                 src_r_last_o, mem_ar_valid_o, mem_ar_ready_i;
    logic                 mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
    logic                 mem_w_last_o, mem_r_valid_i, mem_r_ready_o, mem_r_last_i;
    logic                 mem_b_valid_i, mem_b_ready_o;

    row_t  rows [$];
    row_t  cur;             // row under construction, fields carry over
    int    seed = 14;
    int    test_err = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    wd_limit;
    string test_name [1:6] = '{"single source AR", "AR round robin", "AR back-pressure hold",
                               "W beats in AW order", "AW stall on full write FIFO",
                               "R and B routing by ID"};

    mem_port_merge dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_id(string name, axi_id_t exp, axi_id_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_len(string name, len_t exp, len_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_vec(string name, src_vec_t exp, src_vec_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            test_err++;
        end
    endtask

    // --------------------
    // table building
    // --------------------
    task automatic ar_row(src_vec_t v, src_idx_t g, src_vec_t rdy);
        cur.ar_v         = v;
        cur.e_ar_id      = cur.ar_id[g];
        cur.e_ar_addr    = cur.ar_addr[g];
        cur.e_ar_len     = cur.ar_len[g];
        cur.e_mem_vld[0] = |v;  // any request shows up downstream
        cur.e_ar_rdy     = rdy;
        rows.push_back(cur);
    endtask

    task automatic wr_row(src_vec_t aw_v, src_idx_t aw_g, logic aw_vld, src_vec_t aw_rdy,
                          src_vec_t w_v, src_vec_t w_last, src_idx_t head, logic w_vld,
                          src_vec_t w_rdy);
        cur.aw_v         = aw_v;
        cur.e_aw_id      = cur.aw_id[aw_g];
        cur.e_aw_addr    = cur.aw_addr[aw_g];
        cur.e_aw_len     = cur.aw_len[aw_g];
        cur.e_mem_vld[1] = aw_vld;
        cur.e_aw_rdy     = aw_rdy;
        cur.w_v          = w_v;
        cur.w_last       = w_last;
        cur.e_w_data     = cur.w_data[head];
        cur.e_w_last     = w_last[head];
        cur.e_mem_vld[2] = w_vld;
        cur.e_w_rdy      = w_rdy;
        rows.push_back(cur);
    endtask

    task automatic rb_row(axi_id_t r_id, axi_id_t b_id, logic v, logic last,
                          src_vec_t r_sel, src_vec_t b_sel, src_vec_t mem_rdy);
        cur.mem_r_id   = r_id;
        cur.mem_b_id   = b_id;
        cur.mem_r_v    = v;
        cur.mem_b_v    = v;
        cur.mem_r_data = {$random(seed), $random(seed)};
        cur.mem_r_last = last;
        cur.e_r_v      = r_sel;
        cur.e_b_v      = b_sel;
        cur.e_mem_rdy  = mem_rdy;
        rows.push_back(cur);
    endtask

    task automatic set_defaults();
        cur            = '{default: '0};
        cur.r_rdy      = '1;
        cur.b_rdy      = '1;
        cur.mem_ar_rdy = 1'b1;
        cur.mem_aw_rdy = 1'b1;
        cur.mem_w_rdy  = 1'b1;
        cur.e_mem_rdy  = 3'b011;  // ID 0000 goes to the icache, which is ready
        for (int s = 0; s < NumSrc; s++) begin
            cur.ar_addr[s] = $random(seed) & 32'hffff_ffc0;  // line aligned
            cur.aw_addr[s] = $random(seed) & 32'hffff_ffc0;
        end
        cur.ar_id  = {4'h3, 2'b10, 2'($random(seed)), 4'hc};
        cur.aw_id  = {4'h0, 2'b10, 2'($random(seed)), 4'hc};
        cur.ar_len = {8'd3, 8'd0, 8'd7};
        cur.aw_len = {8'd0, 8'd0, 8'd1};
    endtask

    task automatic build_table();
        cur.test = 1;
        ar_row(3'b010, SrcBypass, 3'b010);
        ar_row(3'b100, SrcIcache, 3'b100);
        ar_row(3'b000, SrcDcache, 3'b000);
        cur.test = 2;  // pointer back at the dcache
        ar_row(3'b111, SrcDcache, 3'b001);
        ar_row(3'b111, SrcBypass, 3'b010);
        ar_row(3'b111, SrcIcache, 3'b100);
        ar_row(3'b111, SrcDcache, 3'b001);
        ar_row(3'b000, SrcDcache, 3'b000);
        cur.test       = 3;
        cur.mem_ar_rdy = 1'b0;
        ar_row(3'b101, SrcIcache, 3'b000);
        ar_row(3'b111, SrcIcache, 3'b000);  // bypass would win without the lock
        cur.mem_ar_rdy = 1'b1;
        ar_row(3'b111, SrcIcache, 3'b100);
        ar_row(3'b011, SrcDcache, 3'b001);
        ar_row(3'b010, SrcBypass, 3'b010);
        ar_row(3'b000, SrcDcache, 3'b000);
        cur.test                = 4;
        cur.w_data[SrcBypass] = {$random(seed), $random(seed)};
        cur.w_data[SrcDcache] = {$random(seed), $random(seed)};
        wr_row(3'b010, SrcBypass, 1'b1, 3'b010, 3'b010, 3'b010, SrcBypass, 1'b0, 3'b000);
        wr_row(3'b001, SrcDcache, 1'b1, 3'b001, 3'b011, 3'b010, SrcBypass, 1'b1, 3'b010);
        wr_row(3'b000, SrcDcache, 1'b0, 3'b000, 3'b001, 3'b000, SrcDcache, 1'b1, 3'b001);
        cur.w_data[SrcDcache] = {$random(seed), $random(seed)};  // second beat
        wr_row(3'b000, SrcDcache, 1'b0, 3'b000, 3'b001, 3'b001, SrcDcache, 1'b1, 3'b001);
        wr_row(3'b000, SrcDcache, 1'b0, 3'b000, 3'b000, 3'b000, SrcDcache, 1'b0, 3'b000);
        cur.test = 5;
        wr_row(3'b111, SrcBypass, 1'b1, 3'b010, 3'b000, 3'b000, SrcDcache, 1'b0, 3'b000);
        wr_row(3'b111, SrcIcache, 1'b1, 3'b100, 3'b000, 3'b000, SrcBypass, 1'b0, 3'b010);
        wr_row(3'b111, SrcDcache, 1'b1, 3'b001, 3'b000, 3'b000, SrcBypass, 1'b0, 3'b010);
        wr_row(3'b111, SrcBypass, 1'b1, 3'b010, 3'b000, 3'b000, SrcBypass, 1'b0, 3'b010);
        wr_row(3'b100, SrcIcache, 1'b0, 3'b000, 3'b000, 3'b000, SrcBypass, 1'b0, 3'b010);
        cur.w_data[SrcBypass] = {$random(seed), $random(seed)};
        wr_row(3'b100, SrcIcache, 1'b0, 3'b000, 3'b010, 3'b010, SrcBypass, 1'b1, 3'b010);
        wr_row(3'b100, SrcIcache, 1'b1, 3'b100, 3'b000, 3'b000, SrcIcache, 1'b0, 3'b100);
        wr_row(3'b000, SrcIcache, 1'b0, 3'b000, 3'b000, 3'b000, SrcIcache, 1'b0, 3'b100);
        cur.test  = 6;
        cur.r_rdy = 3'b101;
        cur.b_rdy = 3'b010;
        rb_row(4'b1100, 4'b1100, 1'b1, 1'b1, 3'b001, 3'b001, 3'b001);
        rb_row({2'b10, 2'($random(seed))}, 4'b1011, 1'b1, 1'b0, 3'b010, 3'b010, 3'b010);
        rb_row(4'b0000, 4'b0000, 1'b1, 1'b1, 3'b100, 3'b100, 3'b001);
        rb_row(4'b1101, 4'b0111, 1'b1, 1'b1, 3'b100, 3'b100, 3'b001);  // unlisted IDs
        rb_row(4'b1100, 4'b1001, 1'b0, 1'b0, 3'b000, 3'b000, 3'b011);
    endtask

    // --------------------
    // drive and check
    // --------------------
    task automatic drive_row(row_t rw);
        src_ar_valid_i <= rw.ar_v;
        src_ar_id_i    <= rw.ar_id;
        src_ar_addr_i  <= rw.ar_addr;
        src_ar_len_i   <= rw.ar_len;
        src_aw_valid_i <= rw.aw_v;
        src_aw_id_i    <= rw.aw_id;
        src_aw_addr_i  <= rw.aw_addr;
        src_aw_len_i   <= rw.aw_len;
        src_w_valid_i  <= rw.w_v;
        src_w_data_i   <= rw.w_data;
        src_w_last_i   <= rw.w_last;
        src_r_ready_i  <= rw.r_rdy;
        src_b_ready_i  <= rw.b_rdy;
        mem_ar_ready_i <= rw.mem_ar_rdy;
        mem_aw_ready_i <= rw.mem_aw_rdy;
        mem_w_ready_i  <= rw.mem_w_rdy;
        mem_r_valid_i  <= rw.mem_r_v;
        mem_r_id_i     <= rw.mem_r_id;
        mem_r_data_i   <= rw.mem_r_data;
        mem_r_last_i   <= rw.mem_r_last;
        mem_b_valid_i  <= rw.mem_b_v;
        mem_b_id_i     <= rw.mem_b_id;
    endtask

    task automatic check_row(row_t rw);
        check_vec("mem valid {w,aw,ar}", rw.e_mem_vld,
                  {mem_w_valid_o, mem_aw_valid_o, mem_ar_valid_o});
        check_vec("mem ready {b,r}", rw.e_mem_rdy, {1'b0, mem_b_ready_o, mem_r_ready_o});
        check_vec("src_ar_ready_o", rw.e_ar_rdy, src_ar_ready_o);
        check_vec("src_aw_ready_o", rw.e_aw_rdy, src_aw_ready_o);
        check_vec("src_w_ready_o", rw.e_w_rdy, src_w_ready_o);
        check_vec("src_r_valid_o", rw.e_r_v, src_r_valid_o);
        check_vec("src_b_valid_o", rw.e_b_v, src_b_valid_o);
        if (rw.e_mem_vld[0]) begin
            check_id("mem_ar_id_o", rw.e_ar_id, mem_ar_id_o);
            check_addr("mem_ar_addr_o", rw.e_ar_addr, mem_ar_addr_o);
            check_len("mem_ar_len_o", rw.e_ar_len, mem_ar_len_o);
        end
        if (rw.e_mem_vld[1]) begin
            check_id("mem_aw_id_o", rw.e_aw_id, mem_aw_id_o);
            check_addr("mem_aw_addr_o", rw.e_aw_addr, mem_aw_addr_o);
            check_len("mem_aw_len_o", rw.e_aw_len, mem_aw_len_o);
        end
        if (rw.e_mem_vld[2]) begin
            check_data("mem_w_data_o", rw.e_w_data, mem_w_data_o);
            check_bit("mem_w_last_o", rw.e_w_last, mem_w_last_o);
        end
        check_id("src_r_id_o", rw.mem_r_id, src_r_id_o);  // broadcast
        check_data("src_r_data_o", rw.mem_r_data, src_r_data_o);
        check_bit("src_r_last_o", rw.mem_r_last, src_r_last_o);
        check_id("src_b_id_o", rw.mem_b_id, src_b_id_o);
    endtask

    task automatic report_test(int t);
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d mismatches", t, test_name[t], test_err);
        end
        test_err = 0;
    endtask

    initial begin
        rst_i = 1'b1;
        set_defaults();
        drive_row(cur);
        build_table();
        wd_limit = (rows.size() + 10) * 8 * 2;
        fork
            begin
                #(wd_limit);
                $display("watchdog expired before the table was applied");
                $display("Some tests failed");
                $finish;
            end
        join_none
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk_i);
            drive_row(rows[i]);
            @(negedge clk_i);  // combinational paths settled
            check_row(rows[i]);
            if (i + 1 == rows.size()) begin
                report_test(rows[i].test);
            end else if (rows[i + 1].test != rows[i].test) begin
                report_test(rows[i].test);
            end
        end
        $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/mem_merge_pkg.sv
hw/addr_chan_if.sv
hw/addr_arbiter.sv
hw/wdata_router.sv
hw/resp_router.sv
hw/mem_port_merge.sv
sim/tb_mem_port_merge.sv

// ==== Bender.yml ====
package:
  name: mem_port_merge

dependencies: {}

sources:
  - files:
      - hw/mem_merge_pkg.sv
      - hw/addr_chan_if.sv
      - hw/addr_arbiter.sv
      - hw/wdata_router.sv
      - hw/resp_router.sv
      - hw/mem_port_merge.sv

  - target: simulation
    files:
      - sim/tb_mem_port_merge.sv
